/* compile.f */
+incdir+src
src/stream_pkg.sv
src/mm_pkg.sv
src/stream_fifo.sv
src/burst_ctrl.sv
src/ds_mm_burst_buffer.sv
test/burst_mem_model.sv
test/tb_ds_mm_burst_buffer.sv

/* Makefile */
TOOL  := verilator
FLAGS := --binary -Wno-fatal
TOP   := tb_ds_mm_burst_buffer
FLIST := compile.f
OBJ   := obj_dir
LOG   := sim.log
PASS  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

run: build
	$(OBJ)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)

/* test/tb_ds_mm_burst_buffer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bstbuf_cfg.svh"

module tb_ds_mm_burst_buffer;
    import stream_pkg::*;
    import mm_pkg::*;

    localparam int RING       = 1 << `BST_AWIDTH;
    localparam int BURST_MAX  = `BST_BURST_MAX;
    localparam int CAPACITY   = `BST_IDEPTH + RING + `BST_ODEPTH;
    localparam int WAIT_LIMIT = 20000;          // Cycles per wait loop

    logic        clk;
    logic        i_rst;
    word_t       i_dat;
    logic        i_val;
    logic        i_rdy;
    word_t       o_dat;
    logic        o_val;
    logic        o_rdy;
    addr_t       m_addr;
    bcnt_t       m_bcnt;
    logic        m_wreq;
    word_t       m_wdat;
    logic        m_rreq;
    word_t       m_rdat;
    logic        m_rval;
    logic        m_busy;
    logic        mem_stall;
    logic [2:0]  mem_lat;
    logic [31:0] stim_state;                    // Stream stalls
    logic [31:0] mem_state;                     // Bus waits from their own sequence
    word_t       sb [$];                        // Accepted words in arrival order
    word_t       next_dat;
    int          n_acc;
    int          n_out;
    int          n_checks;
    int          errors;
    addr_t       wr_next;                       // Where the next write burst has to start
    addr_t       rd_next;
    logic        wr_open;
    int          wr_beats;
    int          wr_len;

    ds_mm_burst_buffer u_dut (
        .clk (clk), .i_rst (i_rst),
        .i_dat (i_dat), .i_val (i_val), .i_rdy (i_rdy),
        .o_dat (o_dat), .o_val (o_val), .o_rdy (o_rdy),
        .o_m_addr (m_addr), .o_m_bcnt (m_bcnt), .o_m_wreq (m_wreq), .o_m_wdat (m_wdat),
        .o_m_rreq (m_rreq), .i_m_rdat (m_rdat), .i_m_rval (m_rval), .i_m_busy (m_busy)
    );

    burst_mem_model u_mem (
        .clk (clk), .i_rst (i_rst),
        .i_addr (m_addr), .i_bcnt (m_bcnt), .i_wreq (m_wreq), .i_wdat (m_wdat),
        .i_rreq (m_rreq), .o_rdat (m_rdat), .o_rval (m_rval), .o_busy (m_busy),
        .i_stall (mem_stall), .i_lat (mem_lat)
    );

    always #2 clk = ~clk;                       // 4 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Clamp len to 1 .. BURST_MAX without passing the ring end
    function automatic int fit_len(input int addr, input int len);
        int lim;
        lim = (RING - addr < BURST_MAX) ? RING - addr : BURST_MAX;
        if (len < 1)
            return 1;
        return (len > lim) ? lim : len;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    //------------------------------------------------------------------------
    // One clock of stimulus plus scoreboard update
    task automatic step_cycle(input int target, input bit rnd_val, input int rdy_mode);
        bit want_val;
        @(posedge clk);
        stim_state = xorshift(stim_state);
        if (i_val && i_rdy) begin                       // Input handshake
            sb.push_back(i_dat);
            n_acc++;
            next_dat = word_t'(next_dat + 8'd1);
        end
        if (o_val && o_rdy) begin                       // Output handshake
            n_out++;
            if (sb.size() == 0) begin
                errors++;
                $display("Output word 0x%0h arrived with no input word pending", o_dat);
            end else
                check_eq("o_dat", o_dat, sb.pop_front());
        end
        want_val = (n_acc < target) && (!rnd_val || stim_state[2:0] != 3'd0);
        if (!(i_val && !i_rdy)) begin                   // Else hold until taken
            i_val <= want_val;
            i_dat <= next_dat;
        end
        case (rdy_mode)
            0:       o_rdy <= 1'b0;
            1:       o_rdy <= 1'b1;
            default: o_rdy <= (stim_state[5:4] != 2'd0);
        endcase
    endtask

    // Offer n more words and wait until the scoreboard drains
    task automatic run_stream(input int n, input bit rnd_val, input int rdy_mode);
        int target;
        int cycles;
        target = n_acc + n;
        cycles = 0;
        while ((n_acc < target || sb.size() != 0) && cycles < WAIT_LIMIT) begin
            step_cycle(target, rnd_val, rdy_mode);
            cycles++;
        end
        if (cycles >= WAIT_LIMIT) begin
            errors++;
            $display("Timeout: stream did not drain, %0d words outstanding", sb.size());
        end
    endtask

    task automatic check_idle_outputs();
        check_eq("o_val", o_val, 0);
        check_eq("o_m_wreq", m_wreq, 0);
        check_eq("o_m_rreq", m_rreq, 0);
    endtask

    //------------------------------------------------------------------------
    // Directed tests
    task automatic test_reset();
        @(posedge clk);                                 // First reset edge clears the state
        repeat (7) begin
            @(posedge clk);
            check_idle_outputs();
        end
        i_rst <= 1'b0;
        @(posedge clk);                                 // First cycle out of reset
        check_idle_outputs();
        check_eq("i_rdy", i_rdy, 1);
    endtask

    task automatic test_straight();
        int start_out;
        start_out = n_out;
        run_stream(40, 1'b0, 1);
        check_eq("n_out", n_out - start_out, 40);
    endtask

    task automatic test_backpressure();
        int start;
        int start_out;
        int low_run;
        int cycles;
        start     = n_acc;
        start_out = n_out;
        low_run   = 0;
        cycles    = 0;
        while (low_run < 200 && cycles < WAIT_LIMIT) begin
            step_cycle(start + 2 * CAPACITY, 1'b0, 0);  // Offer every cycle with o_rdy low
            low_run = i_rdy ? 0 : low_run + 1;
            cycles++;
        end
        if (cycles >= WAIT_LIMIT) begin
            errors++;
            $display("Timeout: i_rdy never stayed low for 200 cycles");
        end
        check_eq("accepted", n_acc - start, CAPACITY);
        run_stream(0, 1'b0, 1);                         // Release and drain
        check_eq("n_out", n_out - start_out, n_acc - start);
    endtask

    task automatic test_random_stalls();
        run_stream(300, 1'b1, 2);
        check_eq("sb_size", sb.size(), 0);
    endtask

    //------------------------------------------------------------------------
    // Memory waits and burst rule monitor
    always @(posedge clk) begin
        mem_state = xorshift(mem_state);
        mem_stall <= (mem_state[1:0] == 2'd0);          // Busy about one cycle in four
        mem_lat   <= 3'(1 + mem_state[10:8] % 6);       // 1 .. 6
    end

    always @(posedge clk) begin
        if (i_rst) begin
            wr_next = '0;
            rd_next = '0;
            wr_open = 1'b0;
        end else begin
            if (m_wreq) begin
                if (!wr_open) begin                     // First beat of a write burst
                    check_eq("o_m_addr", m_addr, wr_next);
                    check_eq("o_m_bcnt", m_bcnt, fit_len(m_addr, m_bcnt));
                    wr_next  = addr_t'(32'(m_addr) + 32'(m_bcnt));  // Ring wrap
                    wr_len   = m_bcnt;
                    wr_beats = 0;
                    wr_open  = 1'b1;
                end
                if (!m_busy)
                    wr_beats++;
            end else if (wr_open) begin
                check_eq("write_beats", wr_beats, wr_len);
                wr_open = 1'b0;
            end
            if (m_rreq && !m_busy) begin                // Accepted read request
                check_eq("o_m_addr", m_addr, rd_next);
                check_eq("o_m_bcnt", m_bcnt, fit_len(m_addr, m_bcnt));
                rd_next = addr_t'(32'(m_addr) + 32'(m_bcnt));
            end
        end
    end

    initial begin
        clk        = 1'b0;
        i_rst      = 1'b1;
        i_dat      = '0;
        i_val      = 1'b0;
        o_rdy      = 1'b0;
        mem_stall  = 1'b0;
        mem_lat    = 3'd1;
        stim_state = 32'h7f98;
        mem_state  = 32'h7f98 ^ 32'h9e37_79b9;
        next_dat   = '0;
        n_acc      = 0;
        n_out      = 0;
        n_checks   = 0;
        errors     = 0;
        test_reset();
        test_straight();
        test_backpressure();
        test_random_stalls();
        $display("Checks run: %0d, errors: %0d", n_checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* test/burst_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bstbuf_cfg.svh"

module burst_mem_model (
    input  wire logic               clk,
    input  wire logic               i_rst,
    // Burst bus, slave side
    input  wire mm_pkg::addr_t      i_addr,
    input  wire mm_pkg::bcnt_t      i_bcnt,
    input  wire logic               i_wreq,
    input  wire stream_pkg::word_t  i_wdat,
    input  wire logic               i_rreq,
    output stream_pkg::word_t       o_rdat,
    output logic                    o_rval,
    output logic                    o_busy,
    // Wait pattern from the testbench
    input  wire logic               i_stall,    // Waitrequest, also gaps in read data
    input  wire logic [2:0]         i_lat       // Cycles before a new read starts to return
);
    import stream_pkg::*;
    import mm_pkg::*;

    word_t      mem [RING_WORDS];
    addr_t      wr_addr;            // Next beat of an open write burst
    bcnt_t      wr_left;            // Zero between bursts
    addr_t      rd_addr;
    bcnt_t      rd_left;            // Words still to return
    logic [2:0] rd_wait;

    assign o_busy = i_stall;

    always @(posedge clk) begin
        if (i_rst) begin
            wr_left <= '0;
            rd_left <= '0;
            rd_wait <= '0;
            o_rval  <= 1'b0;
        end else begin
            o_rval <= 1'b0;
            if (i_wreq && !i_stall) begin
                if (wr_left == '0) begin            // First beat carries addr and length
                    mem[i_addr] <= i_wdat;
                    wr_addr     <= i_addr + 1'b1;
                    wr_left     <= i_bcnt - 1'b1;
                end else begin
                    mem[wr_addr] <= i_wdat;
                    wr_addr      <= wr_addr + 1'b1;
                    wr_left      <= wr_left - 1'b1;
                end
            end
            if (i_rreq && !i_stall) begin           // Single accepted request
                rd_addr <= i_addr;
                rd_left <= i_bcnt;
                rd_wait <= i_lat;
            end else if (rd_left != '0) begin
                if (rd_wait != '0)
                    rd_wait <= rd_wait - 1'b1;      // Initial latency
                else if (!i_stall) begin            // Gap while stalled
                    o_rval  <= 1'b1;
                    o_rdat  <= mem[rd_addr];
                    rd_addr <= rd_addr + 1'b1;
                    rd_left <= rd_left - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/ds_mm_burst_buffer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bstbuf_cfg.svh"

module ds_mm_burst_buffer (
    input  wire logic               clk,
    input  wire logic               i_rst,
    // Input stream
    input  wire stream_pkg::word_t  i_dat,
    input  wire logic               i_val,
    output logic                    i_rdy,
    // Output stream
    output stream_pkg::word_t       o_dat,
    output logic                    o_val,
    input  wire logic               o_rdy,
    // Burst memory bus
    output mm_pkg::addr_t           o_m_addr,
    output mm_pkg::bcnt_t           o_m_bcnt,
    output logic                    o_m_wreq,
    output stream_pkg::word_t       o_m_wdat,
    output logic                    o_m_rreq,
    input  wire stream_pkg::word_t  i_m_rdat,
    input  wire logic               i_m_rval,
    input  wire logic               i_m_busy
);
    import stream_pkg::*;

    //------------------------------------------------------------------------
    // Links between the FIFOs and the controller
    word_t  wr_dat;     // Input FIFO head
    logic   wr_val;
    logic   wr_rdy;
    level_t wr_level;
    word_t  rd_dat;     // Read return into output FIFO
    logic   rd_val;
    level_t rd_level;

    stream_fifo #(.DEPTH(`BST_IDEPTH)) u_in_fifo (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_dat   (i_dat),
        .i_val   (i_val),
        .i_rdy   (i_rdy),
        .o_dat   (wr_dat),
        .o_val   (wr_val),
        .o_rdy   (wr_rdy),
        .o_level (wr_level)
    );

    burst_ctrl u_burst_ctrl (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_wr_dat   (wr_dat),
        .i_wr_val   (wr_val),
        .i_wr_level (wr_level),
        .o_wr_rdy   (wr_rdy),
        .o_rd_dat   (rd_dat),
        .o_rd_val   (rd_val),
        .i_rd_level (rd_level),
        .o_m_addr   (o_m_addr),
        .o_m_bcnt   (o_m_bcnt),
        .o_m_wreq   (o_m_wreq),
        .o_m_wdat   (o_m_wdat),
        .o_m_rreq   (o_m_rreq),
        .i_m_rdat   (i_m_rdat),
        .i_m_rval   (i_m_rval),
        .i_m_busy   (i_m_busy)
    );

    stream_fifo #(.DEPTH(`BST_ODEPTH)) u_out_fifo (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_dat   (rd_dat),
        .i_val   (rd_val),
        .i_rdy   (),            // Room reserved before each read burst
        .o_dat   (o_dat),
        .o_val   (o_val),
        .o_rdy   (o_rdy),
        .o_level (rd_level)
    );

endmodule

`default_nettype wire

/* src/burst_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bstbuf_cfg.svh"

module burst_ctrl (
    input  wire logic               clk,
    input  wire logic               i_rst,
    // Input FIFO pop side
    input  wire stream_pkg::word_t  i_wr_dat,
    input  wire logic               i_wr_val,
    input  wire stream_pkg::level_t i_wr_level,
    output logic                    o_wr_rdy,
    // Output FIFO push side
    output stream_pkg::word_t       o_rd_dat,
    output logic                    o_rd_val,
    input  wire stream_pkg::level_t i_rd_level,
    // Memory bus master
    output mm_pkg::addr_t           o_m_addr,
    output mm_pkg::bcnt_t           o_m_bcnt,
    output logic                    o_m_wreq,
    output stream_pkg::word_t       o_m_wdat,
    output logic                    o_m_rreq,
    input  wire stream_pkg::word_t  i_m_rdat,
    input  wire logic               i_m_rval,
    input  wire logic               i_m_busy
);
    import stream_pkg::*;
    import mm_pkg::*;

    localparam int unsigned BURST_MAX = `BST_BURST_MAX;
    localparam int unsigned FW        = `BST_AWIDTH + 1;

    typedef logic [FW-1:0] fill_t;      // 0 .. RING_WORDS

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITE,        // Write beats in flight
        S_RD_ISSUE,     // Read request until accepted
        S_RD_WAIT       // Collecting returned words
    } state_t;

    state_t         state;
    addr_t          wr_ptr;             // Next ring word to write
    addr_t          rd_ptr;             // Next ring word to read
    fill_t          stored;             // Words parked in the ring
    bcnt_t          beats;              // Beats left in this burst
    logic           prio_wr;            // Writes win the next tie
    level_t         rd_space;           // Free words in the output FIFO
    int unsigned    wr_len;
    int unsigned    rd_len;
    logic           wr_go;
    logic           rd_go;
    logic           take_wr;
    logic           wr_beat;
    logic           rd_beat;

    function automatic int unsigned min4(
        input int unsigned a,
        input int unsigned b,
        input int unsigned c,
        input int unsigned d
    );
        int unsigned m;
        m = a;
        if (b < m) m = b;
        if (c < m) m = c;
        if (d < m) m = d;
        return m;
    endfunction

    //------------------------------------------------------------------------
    // Burst sizing
    // Never past the ring end, never more than the output FIFO can take
    assign rd_space = level_t'(`BST_ODEPTH) - i_rd_level;

    always_comb begin
        wr_len  = min4(32'(i_wr_level), RING_WORDS - 32'(stored),
                       RING_WORDS - 32'(wr_ptr), BURST_MAX);
        rd_len  = min4(32'(stored), 32'(rd_space),
                       RING_WORDS - 32'(rd_ptr), BURST_MAX);
        wr_go   = (wr_len != 0);
        rd_go   = (rd_len != 0);
        take_wr = wr_go && (prio_wr || !rd_go);   // Alternate on ties
    end

    //------------------------------------------------------------------------
    // Bus side
    assign o_m_wreq = (state == S_WRITE) && i_wr_val;   // Level guarantees val
    assign o_m_wdat = i_wr_dat;                         // FIFO head is the beat
    assign o_wr_rdy = (state == S_WRITE) && !i_m_busy;  // Pop on completed beat
    assign wr_beat  = o_m_wreq && !i_m_busy;
    assign o_m_rreq = (state == S_RD_ISSUE);
    assign rd_beat  = (state == S_RD_WAIT) && i_m_rval;

    // Read return, space already reserved
    assign o_rd_val = rd_beat;
    assign o_rd_dat = i_m_rdat;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state   <= S_IDLE;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            stored  <= '0;
            beats   <= '0;
            prio_wr <= 1'b1;
        end else begin
            case (state)
                S_IDLE: begin
                    if (take_wr) begin
                        state   <= S_WRITE;
                        beats   <= bcnt_t'(wr_len);
                        prio_wr <= 1'b0;
                    end else if (rd_go) begin
                        state   <= S_RD_ISSUE;
                        beats   <= bcnt_t'(rd_len);
                        prio_wr <= 1'b1;
                    end
                end
                S_WRITE: begin
                    if (wr_beat) begin
                        beats <= beats - 1'b1;
                        if (beats == bcnt_t'(1)) begin          // Last beat
                            state  <= S_IDLE;
                            wr_ptr <= wr_ptr + addr_t'(o_m_bcnt);  // Wraps at ring end
                            stored <= stored + fill_t'(o_m_bcnt);
                        end
                    end
                end
                S_RD_ISSUE: begin
                    if (!i_m_busy)
                        state <= S_RD_WAIT;
                end
                S_RD_WAIT: begin
                    if (rd_beat) begin
                        beats <= beats - 1'b1;
                        if (beats == bcnt_t'(1)) begin          // Last word back
                            state  <= S_IDLE;
                            rd_ptr <= rd_ptr + addr_t'(o_m_bcnt);
                            stored <= stored - fill_t'(o_m_bcnt);
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Address and length latched on the way out of idle
    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            o_m_addr <= take_wr ? wr_ptr : rd_ptr;
            o_m_bcnt <= take_wr ? bcnt_t'(wr_len) : bcnt_t'(rd_len);
        end
    end

endmodule

`default_nettype wire

/* src/stream_fifo.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bstbuf_cfg.svh"

module stream_fifo #(
    parameter int unsigned DEPTH = `BST_IDEPTH
) (
    input  wire logic               clk,
    input  wire logic               i_rst,
    // Push side
    input  wire stream_pkg::word_t  i_dat,
    input  wire logic               i_val,
    output logic                    i_rdy,
    // Pop side
    output stream_pkg::word_t       o_dat,
    output logic                    o_val,
    input  wire logic               o_rdy,
    // Occupancy for burst sizing
    output stream_pkg::level_t      o_level
);
    import stream_pkg::*;

    localparam int unsigned PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    word_t          mem [DEPTH];    // Storage, no reset
    logic [PW-1:0]  wr_ptr;
    logic [PW-1:0]  rd_ptr;
    level_t         count;          // Words held
    logic           push;
    logic           pop;

    // Pointer step with wrap at DEPTH, which need not be a power of two
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    //------------------------------------------------------------------------
    // Handshakes straight from the count
    assign i_rdy   = (count != level_t'(DEPTH));
    assign o_val   = (count != '0);
    assign push    = i_val & i_rdy;
    assign pop     = o_val & o_rdy;
    assign o_dat   = mem[rd_ptr];   // Head word, visible the cycle after its push
    assign o_level = count;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                      // None, or both at once
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= i_dat;
    end

endmodule

`default_nettype wire

/* src/mm_pkg.sv */
`default_nettype none
`include "bstbuf_cfg.svh"

package mm_pkg;

    // Words in the ring, i.e. the whole external address space
    localparam int unsigned RING_WORDS = 1 << `BST_AWIDTH;

    typedef logic [`BST_AWIDTH-1:0] addr_t;     // Word address
    typedef logic [`BST_BWIDTH-1:0] bcnt_t;     // Burst length in words

endpackage

`default_nettype wire

/* src/stream_pkg.sv */
`default_nettype none
`include "bstbuf_cfg.svh"

package stream_pkg;

    // Deeper of the two FIFOs, sets the level width
    localparam int unsigned LEVEL_MAX =
        (`BST_IDEPTH > `BST_ODEPTH) ? `BST_IDEPTH : `BST_ODEPTH;

    typedef logic [`BST_DWIDTH-1:0]           word_t;     // One stream word
    typedef logic [$clog2(LEVEL_MAX + 1)-1:0] level_t;    // 0 .. LEVEL_MAX inclusive

endpackage

`default_nettype wire

/* src/bstbuf_cfg.svh */
`ifndef BSTBUF_CFG_SVH
`define BSTBUF_CFG_SVH

//----------------------------------------------------------------------------
// Stream side
`define BST_DWIDTH      8       // Word width
`define BST_IDEPTH      16      // Input FIFO words
`define BST_ODEPTH      16      // Output FIFO words

//----------------------------------------------------------------------------
// Memory side
`define BST_AWIDTH      6       // Ring of 64 words
`define BST_BWIDTH      4       // Burst count field

// Longest burst in words
// Has to fit in BST_BWIDTH bits and divide the ring size evenly
`define BST_BURST_MAX   8

`endif
